// ==== hdl/accel_spi_pkg.sv ====
// ---------------------------------------------------------------------
// SPI side definitions: byte type, command codes, controller states
// ---------------------------------------------------------------------

`default_nettype none

package accel_spi_pkg;

   // Any byte on the SPI wires or in the register map
   typedef logic [7:0] byte_t;

   // Command bytes, first byte of every transaction
   localparam byte_t spi_cmd_write = 8'h0A;
   localparam byte_t spi_cmd_read  = 8'h0B;
   localparam byte_t spi_cmd_fifo  = 8'h0D;

   // Command controller states
   typedef enum logic [2:0] {
      ST_CMD,
      ST_ADDR,
      ST_WR_DATA,
      ST_RD_DATA,
      ST_FIFO_LOW,
      ST_FIFO_HIGH,
      ST_IGNORE
   } ctrl_state_t;

endpackage

`default_nettype wire

// ==== hdl/accel_reg_pkg.sv ====
// ---------------------------------------------------------------------
// Register map addresses, identity values, address and sample types
// ---------------------------------------------------------------------

`default_nettype none

package accel_reg_pkg;

   typedef logic [5:0]  reg_addr_t;
   typedef logic [15:0] sample_t;
   // Holds 0 to fifo_depth
   typedef logic [3:0]  fifo_count_t;

   localparam int fifo_depth = 8;

   // Register addresses
   localparam reg_addr_t reg_devid_ad      = 6'h00;
   localparam reg_addr_t reg_devid_mst     = 6'h01;
   localparam reg_addr_t reg_status        = 6'h0B;
   localparam reg_addr_t reg_fifo_entries  = 6'h0C;
   // Watermark level for the interrupt
   localparam reg_addr_t reg_fifo_samples  = 6'h29;
   localparam reg_addr_t reg_power_ctl     = 6'h2D;
   // Everything from here up is read/write storage
   localparam reg_addr_t reg_writable_base = 6'h20;

   // Identity bytes
   localparam logic [7:0] devid_ad_value  = 8'hAD;
   localparam logic [7:0] devid_mst_value = 8'h1D;

endpackage

`default_nettype wire

// ==== hdl/spi_byte_link.sv ====
// ---------------------------------------------------------------------
// SPI mode 0 byte link, pins oversampled in clk_sys
// ---------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module spi_byte_link import accel_spi_pkg::*; (
   input  logic  clk_sys,
   input  logic  nCS,
   input  logic  sclk,
   input  logic  mosi,
   input  logic  spi_cs_n,
   input  byte_t tx_byte,
   output logic  miso,
   output logic  cs_active,
   output logic  byte_done,
   output byte_t rx_byte
);

   // Bits [1:0] synchronize, bit 2 holds the previous value
   logic [2:0] sclk_sync;
   logic [2:0] cs_sync;
   logic [1:0] mosi_sync;
   logic       sclk_rise;
   logic       sclk_fall;
   logic       cs_start;
   logic [2:0] bit_cnt;
   logic       load_pending;
   byte_t      rx_shift;
   byte_t      tx_shift;

   always_ff @(posedge clk_sys or posedge nCS) begin
      if (nCS) begin
         sclk_sync <= '0;
         cs_sync   <= '1;
         mosi_sync <= '0;
      end else begin
         sclk_sync <= {sclk_sync[1:0], sclk};
         cs_sync   <= {cs_sync[1:0], spi_cs_n};
         mosi_sync <= {mosi_sync[0], mosi};
      end
   end

   assign sclk_rise = sclk_sync[1] & ~sclk_sync[2];
   assign sclk_fall = ~sclk_sync[1] & sclk_sync[2];
   assign cs_active = ~cs_sync[1];
   assign cs_start  = ~cs_sync[1] & cs_sync[2];

   always_ff @(posedge clk_sys or posedge nCS) begin
      if (nCS) begin
         bit_cnt      <= '0;
         rx_shift     <= '0;
         tx_shift     <= '0;
         load_pending <= 1'b0;
         byte_done    <= 1'b0;
      end else begin
         byte_done <= 1'b0;
         if (!cs_active) begin
            // Partial byte is dropped
            bit_cnt      <= '0;
            tx_shift     <= '0;
            load_pending <= 1'b0;
         end else begin
            if (cs_start) begin
               tx_shift <= tx_byte;
            end else if (sclk_fall) begin
               // Next byte goes out on the fall that follows the last bit
               tx_shift     <= load_pending ? tx_byte : {tx_shift[6:0], 1'b0};
               load_pending <= 1'b0;
            end
            if (sclk_rise) begin
               rx_shift <= {rx_shift[6:0], mosi_sync[1]};
               bit_cnt  <= bit_cnt + 3'd1;
               if (bit_cnt == 3'd7) begin
                  byte_done    <= 1'b1;
                  load_pending <= 1'b1;
               end
            end
         end
      end
   end

   assign rx_byte = rx_shift;
   assign miso    = tx_shift[7];

   a_done_in_cs: assert property (@(posedge clk_sys) disable iff (nCS)
      byte_done |-> cs_active)
      else $error("byte_done outside chip select");

endmodule

`default_nettype wire

// ==== hdl/spi_command_ctrl.sv ====
// ---------------------------------------------------------------------
// Command decoder: register write/read bursts and FIFO sample reads
// ---------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module spi_command_ctrl import accel_spi_pkg::*, accel_reg_pkg::*; (
   input  logic      clk_sys,
   input  logic      nCS,
   input  logic      cs_active,
   input  logic      byte_done,
   input  byte_t     rx_byte,
   input  byte_t     rd_data,
   input  sample_t   head_sample,
   input  logic      empty,
   output byte_t     tx_byte,
   output reg_addr_t reg_addr,
   output byte_t     wr_data,
   output logic      wr_strobe,
   output logic      pop
);

   ctrl_state_t state;
   byte_t       cmd;
   // Bump the address one cycle after a data byte
   logic        adv;
   // Low byte of this sample came from a real entry
   logic        have_sample;

   always_ff @(posedge clk_sys or posedge nCS) begin
      if (nCS) begin
         state       <= ST_CMD;
         cmd         <= '0;
         reg_addr    <= '0;
         wr_strobe   <= 1'b0;
         pop         <= 1'b0;
         adv         <= 1'b0;
         have_sample <= 1'b0;
      end else begin
         wr_strobe <= 1'b0;
         pop       <= 1'b0;
         adv       <= 1'b0;
         if (adv) begin
            reg_addr <= reg_addr + 1'b1;
         end
         if (!cs_active) begin
            state <= ST_CMD;
         end else if (byte_done) begin
            case (state)
               ST_CMD: begin
                  cmd <= rx_byte;
                  if (rx_byte == spi_cmd_write || rx_byte == spi_cmd_read) begin
                     state <= ST_ADDR;
                  end else if (rx_byte == spi_cmd_fifo) begin
                     state <= ST_FIFO_LOW;
                  end else begin
                     state <= ST_IGNORE;
                  end
               end
               ST_ADDR: begin
                  reg_addr <= rx_byte[5:0];
                  state    <= (cmd == spi_cmd_write) ? ST_WR_DATA : ST_RD_DATA;
               end
               ST_WR_DATA: begin
                  wr_strobe <= 1'b1;
                  adv       <= 1'b1;
               end
               ST_RD_DATA: begin
                  adv <= 1'b1;
               end
               ST_FIFO_LOW: begin
                  have_sample <= ~empty;
                  state       <= ST_FIFO_HIGH;
               end
               ST_FIFO_HIGH: begin
                  pop   <= have_sample;
                  state <= ST_FIFO_LOW;
               end
               // ST_IGNORE waits for chip select to drop
               default: state <= state;
            endcase
         end
      end
   end

   // Write data is held with the strobe
   always_ff @(posedge clk_sys) begin
      if (byte_done && state == ST_WR_DATA) begin
         wr_data <= rx_byte;
      end
   end

   // Byte offered to the link for the next shift out
   always_comb begin
      case (state)
         ST_RD_DATA:   tx_byte = rd_data;
         ST_FIFO_LOW:  tx_byte = empty ? '0 : head_sample[7:0];
         ST_FIFO_HIGH: tx_byte = have_sample ? head_sample[15:8] : '0;
         default:      tx_byte = '0;
      endcase
   end

   a_wr_one_cycle: assert property (@(posedge clk_sys) disable iff (nCS)
      wr_strobe |=> !wr_strobe)
      else $error("wr_strobe longer than one cycle");

   a_pop_not_empty: assert property (@(posedge clk_sys) disable iff (nCS)
      pop |-> !empty)
      else $error("pop while FIFO empty");

endmodule

`default_nettype wire

// ==== hdl/accel_reg_file.sv ====
// ---------------------------------------------------------------------
// Register map storage, status, measure enable, watermark interrupt
// ---------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module accel_reg_file import accel_spi_pkg::*, accel_reg_pkg::*; (
   input  logic        clk_sys,
   input  logic        nCS,
   input  reg_addr_t   reg_addr,
   input  byte_t       wr_data,
   input  logic        wr_strobe,
   input  fifo_count_t count,
   input  logic        full,
   input  logic        sample_valid,
   output byte_t       rd_data,
   output logic        measure_en,
   output logic        fifo_wm_int
);

   // Addresses 0x20 to 0x3F
   byte_t wr_regs [32];
   logic  overrun;
   logic  wm_hit;

   always_ff @(posedge clk_sys or posedge nCS) begin
      if (nCS) begin
         for (int i = 0; i < $size(wr_regs); i++) begin
            wr_regs[i] <= '0;
         end
         overrun     <= 1'b0;
         fifo_wm_int <= 1'b0;
      end else begin
         // Writes below the writable base are dropped
         if (wr_strobe && reg_addr >= reg_writable_base) begin
            wr_regs[reg_addr[4:0]] <= wr_data;
         end
         // Sticky until reset
         if (sample_valid && measure_en && full) begin
            overrun <= 1'b1;
         end
         fifo_wm_int <= wm_hit;
      end
   end

   // Measurement mode is power_ctl[1:0] == 2'b10
   assign measure_en = (wr_regs[reg_power_ctl[4:0]][1:0] == 2'b10);
   assign wm_hit     = (wr_regs[reg_fifo_samples[4:0]] != '0) &&
                       (byte_t'(count) >= wr_regs[reg_fifo_samples[4:0]]);

   always_comb begin
      case (reg_addr)
         reg_devid_ad:     rd_data = devid_ad_value;
         reg_devid_mst:    rd_data = devid_mst_value;
         reg_status:       rd_data = {5'b0, overrun, fifo_wm_int, (count != '0)};
         reg_fifo_entries: rd_data = byte_t'(count);
         default:          rd_data = (reg_addr >= reg_writable_base) ?
                                     wr_regs[reg_addr[4:0]] : '0;
      endcase
   end

endmodule

`default_nettype wire

// ==== hdl/sample_fifo.sv ====
// ---------------------------------------------------------------------
// Sample FIFO, circular buffer with entry count
// ---------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module sample_fifo import accel_reg_pkg::*; (
   input  logic        clk_sys,
   input  logic        nCS,
   input  logic        push,
   input  sample_t     push_sample,
   input  logic        pop,
   output sample_t     head_sample,
   output logic        empty,
   output logic        full,
   output fifo_count_t count
);

   sample_t                         mem [fifo_depth];
   logic [$clog2(fifo_depth)-1:0]   wr_ptr;
   logic [$clog2(fifo_depth)-1:0]   rd_ptr;
   logic                            do_push;
   logic                            do_pop;

   assign do_push = push & ~full;
   assign do_pop  = pop & ~empty;

   always_ff @(posedge clk_sys or posedge nCS) begin
      if (nCS) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push) wr_ptr <= wr_ptr + 1'b1;
         if (do_pop)  rd_ptr <= rd_ptr + 1'b1;
         // Push and pop together leave the count alone
         if (do_push && !do_pop) begin
            count <= count + 1'b1;
         end else if (do_pop && !do_push) begin
            count <= count - 1'b1;
         end
      end
   end

   always_ff @(posedge clk_sys) begin
      if (do_push) begin
         mem[wr_ptr] <= push_sample;
      end
   end

   assign head_sample = mem[rd_ptr];
   assign empty       = (count == '0);
   assign full        = (count == fifo_count_t'(fifo_depth));

   a_no_push_full: assert property (@(posedge clk_sys) disable iff (nCS)
      push |-> !full)
      else $error("push while FIFO full");

endmodule

`default_nettype wire

// ==== hdl/accel_spi_top.sv ====
// ---------------------------------------------------------------------
// Accelerometer SPI slave top: link, controller, registers, FIFO
// ---------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module accel_spi_top import accel_spi_pkg::*, accel_reg_pkg::*; (
   input  logic    clk_sys,
   input  logic    nCS,
   input  logic    sclk,
   input  logic    mosi,
   input  logic    spi_cs_n,
   output logic    miso,
   input  logic    sample_valid,
   input  sample_t sample_data,
   output logic    fifo_wm_int
);

   logic        cs_active;
   logic        byte_done;
   byte_t       rx_byte;
   byte_t       tx_byte;
   reg_addr_t   reg_addr;
   byte_t       wr_data;
   logic        wr_strobe;
   byte_t       rd_data;
   logic        pop;
   logic        push;
   sample_t     head_sample;
   logic        empty;
   logic        full;
   fifo_count_t count;
   logic        measure_en;

   // Samples enter only in measurement mode and with room left
   assign push = sample_valid & measure_en & ~full;

   spi_byte_link spi_byte_link_i (
      .clk_sys   (clk_sys),
      .nCS       (nCS),
      .sclk      (sclk),
      .mosi      (mosi),
      .spi_cs_n  (spi_cs_n),
      .tx_byte   (tx_byte),
      .miso      (miso),
      .cs_active (cs_active),
      .byte_done (byte_done),
      .rx_byte   (rx_byte)
   );

   spi_command_ctrl spi_command_ctrl_i (
      .clk_sys     (clk_sys),
      .nCS         (nCS),
      .cs_active   (cs_active),
      .byte_done   (byte_done),
      .rx_byte     (rx_byte),
      .rd_data     (rd_data),
      .head_sample (head_sample),
      .empty       (empty),
      .tx_byte     (tx_byte),
      .reg_addr    (reg_addr),
      .wr_data     (wr_data),
      .wr_strobe   (wr_strobe),
      .pop         (pop)
   );

   accel_reg_file accel_reg_file_i (
      .clk_sys      (clk_sys),
      .nCS          (nCS),
      .reg_addr     (reg_addr),
      .wr_data      (wr_data),
      .wr_strobe    (wr_strobe),
      .count        (count),
      .full         (full),
      .sample_valid (sample_valid),
      .rd_data      (rd_data),
      .measure_en   (measure_en),
      .fifo_wm_int  (fifo_wm_int)
   );

   sample_fifo sample_fifo_i (
      .clk_sys     (clk_sys),
      .nCS         (nCS),
      .push        (push),
      .push_sample (sample_data),
      .pop         (pop),
      .head_sample (head_sample),
      .empty       (empty),
      .full        (full),
      .count       (count)
   );

endmodule

`default_nettype wire

// ==== bench/tb_accel_spi.sv ====
// ----------------------------------------------------------------------
// Testbench for the accelerometer SPI slave: SPI master, vector reader,
// compare tasks and error summary
// ----------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module tb_accel_spi import accel_spi_pkg::*, accel_reg_pkg::*;;

   localparam string vector_file    = "bench/accel_spi_vectors.txt";
   localparam int    clk_period     = 4;
   localparam int    sclk_half      = 5;
   localparam int    timeout_cycles = 2000;
   localparam int    max_samples    = 16;

   logic    clk_sys;
   logic    nCS;
   logic    sclk;
   logic    mosi;
   logic    spi_cs_n;
   logic    miso;
   logic    sample_valid;
   sample_t sample_data;
   logic    fifo_wm_int;

   integer  seed = 32'h934e92e3;
   int      op_cycles = 0;
   int      byte_errors = 0;
   int      sample_errors = 0;
   int      int_errors = 0;
   int      other_errors = 0;
   sample_t got_samples [max_samples];

   accel_spi_top accel_spi_top_i (
      .clk_sys      (clk_sys),
      .nCS          (nCS),
      .sclk         (sclk),
      .mosi         (mosi),
      .spi_cs_n     (spi_cs_n),
      .miso         (miso),
      .sample_valid (sample_valid),
      .sample_data  (sample_data),
      .fifo_wm_int  (fifo_wm_int)
   );

   initial begin
      clk_sys = 1'b0;
      forever #(clk_period / 2) clk_sys = ~clk_sys;
   end

   // Leaves the caller 1 ns after a rising edge
   task automatic wait_cycles(input int n);
      repeat (n) @(posedge clk_sys);
      #1;
   endtask

   // Mode 0, MSB first, MISO taken just before the rising SCLK edge
   task automatic spi_byte(input byte_t tx, output byte_t rx);
      for (int i = 7; i >= 0; i--) begin
         mosi = tx[i];
         wait_cycles(sclk_half);
         rx[i] = miso;
         sclk  = 1'b1;
         wait_cycles(sclk_half);
         sclk  = 1'b0;
      end
   endtask

   task automatic spi_begin();
      spi_cs_n = 1'b0;
      wait_cycles(sclk_half);
   endtask

   // Random idle gap of 2 to 10 cycles between transactions
   task automatic spi_end();
      wait_cycles(sclk_half);
      spi_cs_n = 1'b1;
      mosi     = 1'b0;
      wait_cycles(2 + ($unsigned($random(seed)) % 9));
   endtask

   task automatic check_byte(input string name, input byte_t got, input byte_t exp);
      if (got !== exp) begin
         byte_errors++;
         $display("error: %s got 0x%02h expected 0x%02h", name, got, exp);
      end
   endtask

   task automatic check_sample(input string name, input sample_t got, input sample_t exp);
      if (got !== exp) begin
         sample_errors++;
         $display("error: %s got 0x%04h expected 0x%04h", name, got, exp);
      end
   endtask

   task automatic check_int(input logic got, input logic exp);
      if (got !== exp) begin
         int_errors++;
         $display("error: fifo_wm_int got 0x%0h expected 0x%0h", got, exp);
      end
   endtask

   task automatic reg_write(input reg_addr_t addr, input int n, input byte_t d0,
                            input byte_t d1);
      byte_t rx;
      spi_begin();
      spi_byte(spi_cmd_write, rx);
      spi_byte(byte_t'(addr), rx);
      spi_byte(d0, rx);
      if (n > 1) begin
         spi_byte(d1, rx);
      end
      spi_end();
   endtask

   task automatic reg_read(input reg_addr_t addr, input int n, output byte_t r0,
                           output byte_t r1);
      byte_t rx;
      spi_begin();
      spi_byte(spi_cmd_read, rx);
      check_byte("miso during command", rx, 8'h00);
      spi_byte(byte_t'(addr), rx);
      check_byte("miso during address", rx, 8'h00);
      spi_byte(8'h00, r0);
      r1 = '0;
      if (n > 1) begin
         spi_byte(8'h00, r1);
      end
      spi_end();
   endtask

   // Low byte first, then high byte
   task automatic fifo_read(input int n);
      byte_t rx;
      byte_t lo;
      byte_t hi;
      spi_begin();
      spi_byte(spi_cmd_fifo, rx);
      for (int i = 0; i < n; i++) begin
         spi_byte(8'h00, lo);
         spi_byte(8'h00, hi);
         got_samples[i] = {hi, lo};
      end
      spi_end();
   endtask

   task automatic offer_sample(input sample_t s);
      sample_valid = 1'b1;
      sample_data  = s;
      wait_cycles(1);
      sample_valid = 1'b0;
      wait_cycles(1);
   endtask

   // Bounds every single operation
   initial begin
      while (op_cycles <= timeout_cycles) begin
         @(posedge clk_sys);
         op_cycles++;
      end
      $display("timeout: an operation ran longer than %0d clock cycles", timeout_cycles);
      $display("TESTBENCH FAILED");
      $finish;
   end

   initial begin
      int      fd;
      int      code;
      byte_t   op;
      int      a;
      int      d0;
      int      d1;
      int      n;
      int      v;
      int      total;
      string   line;
      byte_t   r0;
      byte_t   r1;
      sample_t exp_samples [max_samples];
      nCS          = 1'b1;
      sclk         = 1'b0;
      mosi         = 1'b0;
      spi_cs_n     = 1'b1;
      sample_valid = 1'b0;
      sample_data  = '0;
      wait_cycles(5);
      nCS = 1'b0;
      wait_cycles(5);
      fd = $fopen(vector_file, "r");
      if (fd == 0) begin
         other_errors++;
         $display("could not open the vector file %s", vector_file);
      end else begin
         while ($fscanf(fd, " %c", op) == 1) begin
            op_cycles = 0;
            case (op)
               "#": code = $fgets(line, fd);
               "W": begin
                  code = $fscanf(fd, "%h %h", a, d0);
                  reg_write(reg_addr_t'(a), 1, byte_t'(d0), 8'h00);
               end
               "B": begin
                  code = $fscanf(fd, "%h %h %h", a, d0, d1);
                  reg_write(reg_addr_t'(a), 2, byte_t'(d0), byte_t'(d1));
               end
               "R": begin
                  code = $fscanf(fd, "%h %h", a, d0);
                  reg_read(reg_addr_t'(a), 1, r0, r1);
                  check_byte($sformatf("miso reg 0x%02h", a), r0, byte_t'(d0));
               end
               "D": begin
                  code = $fscanf(fd, "%h %h %h", a, d0, d1);
                  reg_read(reg_addr_t'(a), 2, r0, r1);
                  check_byte($sformatf("miso reg 0x%02h", a), r0, byte_t'(d0));
                  check_byte($sformatf("miso reg 0x%02h", (a + 1) % 64), r1, byte_t'(d1));
               end
               "P": begin
                  code = $fscanf(fd, "%h", n);
                  for (int i = 0; i < n; i++) begin
                     code = $fscanf(fd, "%h", v);
                     offer_sample(sample_t'(v));
                  end
                  wait_cycles(2);
               end
               "F": begin
                  code = $fscanf(fd, "%h", n);
                  for (int i = 0; i < n; i++) begin
                     code = $fscanf(fd, "%h", v);
                     exp_samples[i] = sample_t'(v);
                  end
                  fifo_read(n);
                  for (int i = 0; i < n; i++) begin
                     check_sample($sformatf("miso sample %0d", i), got_samples[i],
                                  exp_samples[i]);
                  end
               end
               "I": begin
                  code = $fscanf(fd, "%h", v);
                  // Count change plus the interrupt register
                  wait_cycles(6);
                  check_int(fifo_wm_int, v[0]);
               end
               default: begin
                  other_errors++;
                  $display("unknown operation '%c' in the vector file", op);
               end
            endcase
         end
         $fclose(fd);
      end
      total = byte_errors + sample_errors + int_errors + other_errors;
      $display("errors: bytes %0d, samples %0d, interrupt %0d, other %0d, total %0d",
               byte_errors, sample_errors, int_errors, other_errors, total);
      if (total == 0) begin
         $display("TESTBENCH PASSED");
      end else begin
         $display("TESTBENCH FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== bench/accel_spi_vectors.txt ====
# W addr data | B addr d0 d1 | R addr exp | D addr exp0 exp1 (hex)
# P count samples | F count expected samples | I expected fifo_wm_int
# identity bytes are read-only
R 00 AD
R 01 1D
W 00 55
W 01 66
R 00 AD
R 01 1D
# burst write and read, then a burst wrapping past 3F
B 20 12 34
D 20 12 34
B 3F 77 88
R 3F 77
R 00 AD
# samples stay out while power_ctl is 0
P 2 1111 2222
R 0C 00
W 2D 02
P 2 0A01 0B02
R 0C 02
F 1 0A01
R 0C 01
F 1 0B02
R 0C 00
# reading past the stored samples returns zeros
P 1 0C03
F 3 0C03 0000 0000
R 0C 00
# watermark at three entries
W 29 03
P 2 1001 1002
I 0
P 1 1003
I 1
F 1 1001
I 0
F 2 1002 1003
# ninth sample overruns the FIFO
P 9 2001 2002 2003 2004 2005 2006 2007 2008 2009
R 0B 07
F 9 2001 2002 2003 2004 2005 2006 2007 2008 0000
R 0B 04
R 0C 00

// ==== compile.f ====
hdl/accel_spi_pkg.sv
hdl/accel_reg_pkg.sv
hdl/spi_byte_link.sv
hdl/spi_command_ctrl.sv
hdl/accel_reg_file.sv
hdl/sample_fifo.sv
hdl/accel_spi_top.sv
bench/tb_accel_spi.sv

// ==== Bender.yml ====
package:
  name: accel_spi

sources:
  - files:
      - hdl/accel_spi_pkg.sv
      - hdl/accel_reg_pkg.sv
      - hdl/spi_byte_link.sv
      - hdl/spi_command_ctrl.sv
      - hdl/accel_reg_file.sv
      - hdl/sample_fifo.sv
      - hdl/accel_spi_top.sv
  - target: test
    files:
      - bench/tb_accel_spi.sv
